// File: verilog/ir_decd_params.svh
// width macros for the instruction register decode stage
// instruction word, register index, barrier type

`ifndef IR_DECD_PARAMS_SVH
`define IR_DECD_PARAMS_SVH

// instruction word
`define IR_INST_W 32

// register index in rs1, rs2, rd
`define IR_REG_W 5

// barrier type sent to the lsu
`define IR_BAR_W 4

`endif

// File: verilog/rv_inst_pkg.sv
// RISC-V instruction encoding package
// instruction word union with standard and compressed views
// major opcode constants

`include "ir_decd_params.svh"

package rv_inst_pkg;

  // ==============================
  // instruction word views
  // ==============================
  typedef union packed {
    struct packed {
      logic [6:0]           funct7;
      logic [`IR_REG_W-1:0] rs2;
      logic [`IR_REG_W-1:0] rs1;
      logic [2:0]           funct3;
      logic [`IR_REG_W-1:0] rd;
      logic [6:0]           opcode;
    } std;
    struct packed {
      logic [15:0]          unused;   // upper half of a 32-bit slot
      logic [2:0]           c_funct3;
      logic                 c_bit12;
      logic [`IR_REG_W-1:0] c_rd;     // also rs1 for c.jr/c.jalr
      logic [`IR_REG_W-1:0] c_rs2;
      logic [1:0]           c_op;
    } cmp;
  } rv_inst_u;

  // ==============================
  // major opcodes
  // ==============================
  localparam logic [6:0] op_load     = 7'b0000011;
  localparam logic [6:0] op_load_fp  = 7'b0000111; // fp and vector loads
  localparam logic [6:0] op_store    = 7'b0100011;
  localparam logic [6:0] op_store_fp = 7'b0100111; // fp and vector stores
  localparam logic [6:0] op_amo      = 7'b0101111;
  localparam logic [6:0] op_custom0  = 7'b0001011; // vendor reg-offset ld/st
  localparam logic [6:0] op_branch   = 7'b1100011;
  localparam logic [6:0] op_jal      = 7'b1101111;
  localparam logic [6:0] op_jalr     = 7'b1100111;
  localparam logic [6:0] op_auipc    = 7'b0010111;
  localparam logic [6:0] op_misc_mem = 7'b0001111; // fence, fence.i
  localparam logic [6:0] op_fp       = 7'b1010011;
  localparam logic [6:0] op_v        = 7'b1010111;

endpackage

// File: verilog/ir_decd_pkg.sv
// decode result package
// barrier type codes and vector funct3 categories

`include "ir_decd_params.svh"

package ir_decd_pkg;

  // ==============================
  // barrier types
  // ==============================
  localparam logic [`IR_BAR_W-1:0] bar_type_rw  = 4'b1010; // r/w ordering only
  localparam logic [`IR_BAR_W-1:0] bar_type_all = 4'b1111;

  // ==============================
  // vector funct3 categories
  // ==============================
  localparam logic [2:0] opivv = 3'b000;
  localparam logic [2:0] opfvv = 3'b001;
  localparam logic [2:0] opmvv = 3'b010;
  localparam logic [2:0] opivi = 3'b011;
  localparam logic [2:0] opivx = 3'b100;
  localparam logic [2:0] opfvf = 3'b101;
  localparam logic [2:0] opmvx = 3'b110;

endpackage

// File: verilog/ir_decd_if.sv
// decoder flag bundle between the field decoders and the stage register
// one modport per decoder, pipe reads all

`include "ir_decd_params.svh"

interface ir_decd_if;

  // load/store decoder
  logic                 load, store, str, sync, bar;
  logic [`IR_BAR_W-1:0] bar_type;

  // branch decoder
  logic                 rts, pcall, pcfifo;

  // vector/fp decoder
  logic                 vec, fp, vdiv, mfvr, mtvr, vmul, vmla_short;
  logic                 vsetvl, vsetvli, unit_stride, vamo;

  modport lsu (output load, store, str, sync, bar, bar_type);

  modport bju (output rts, pcall, pcfifo);

  modport vfpu (
    output vec, fp, vdiv, mfvr, mtvr, vmul, vmla_short,
    output vsetvl, vsetvli, unit_stride, vamo
  );

  modport pipe (
    input load, store, str, sync, bar, bar_type,
    input rts, pcall, pcfifo,
    input vec, fp, vdiv, mfvr, mtvr, vmul, vmla_short,
    input vsetvl, vsetvli, unit_stride, vamo
  );

endinterface

// File: verilog/ir_decd_lsu.sv
// load/store field decoder
// load, store, reg-offset store, sync, barrier and barrier type

module ir_decd_lsu
  import rv_inst_pkg::*;
  import ir_decd_pkg::*;
(
  input rv_inst_u inst,
  input logic     type_staddr, // amo issued as staddr
  input logic     type_vload,  // vector amo issued as load
  ir_decd_if.lsu  decd
);

  logic [6:0] opc;
  logic [2:0] f3;
  logic [4:0] f5;         // bits 31:27
  logic [4:0] c_key;      // c_funct3 and c_op
  logic [3:0] pred;
  logic [3:0] succ;
  logic       c_load;
  logic       c_store;
  logic       std_load;
  logic       std_store;
  logic       ro_load;
  logic       ro_store;
  logic       lr_sc;
  logic       is_lr;
  logic       is_sc;
  logic       amo_wd;
  logic       amo_as_ld;
  logic       fence;
  logic       fence_i;
  logic       sfence;
  logic       rw_only;

  assign opc   = inst.std.opcode;
  assign f3    = inst.std.funct3;
  assign f5    = inst.std.funct7[6:2];
  assign c_key = {inst.cmp.c_funct3, inst.cmp.c_op};

  // ==============================
  // loads and stores
  // ==============================
  assign c_load = (c_key inside {5'b001_00, 5'b010_00, 5'b011_00, 5'b001_10})
               || (c_key inside {5'b010_10, 5'b011_10})   // c.lwsp, c.ldsp
                  && (inst.cmp.c_rd != '0);
  assign c_store = c_key inside {5'b101_00, 5'b110_00, 5'b111_00,
                                 5'b101_10, 5'b110_10, 5'b111_10};

  assign std_load  = (opc == op_load) && (f3 != 3'b111)      // lb .. lwu
                  || (opc == op_load_fp) && (f3 != 3'b100);  // flh/flw/fld, vld
  assign std_store = (opc == op_store) && !f3[2]              // sb .. sd
                  || (opc == op_store_fp) && (f3 != 3'b100); // fsh/fsw/fsd, vst

  // vendor reg-offset forms, f5[1] picks the unsigned-index variant
  assign ro_load  = (opc == op_custom0) && (f3 == 3'b100) && !f5[0]
                    && (f5[4:2] != 3'b111)                    // lr*, lur*
                 || (opc == op_custom0) && (f3 == 3'b110) && !f5[0]
                    && (f5[4:3] == 2'b01);                    // flr*, flur*
  assign ro_store = (opc == op_custom0) && (f3 == 3'b101) && !f5[0]
                    && !f5[4]                                 // sr*, sur*
                 || (opc == op_custom0) && (f3 == 3'b111) && !f5[0]
                    && (f5[4:3] == 2'b01);                    // fsr*, fsur*

  // ==============================
  // atomics and fences
  // ==============================
  assign lr_sc  = (opc == op_amo) && (f3[2:1] == 2'b01);     // .w and .d
  assign is_lr  = lr_sc && (f5 == 5'b00010) && (inst.std.rs2 == '0);
  assign is_sc  = lr_sc && (f5 == 5'b00011);
  assign amo_wd = (opc == op_amo) && f3[1]                    // bit 14 free for vamo
               && (f5 inside {5'b00000, 5'b00001, 5'b00100, 5'b01100, 5'b01000,
                              5'b10000, 5'b10100, 5'b11000, 5'b11100});
  assign amo_as_ld = f3[2] ? type_vload : !type_staddr;

  assign fence   = (opc == op_misc_mem) && (f3 == 3'b000);
  assign fence_i = (opc == op_misc_mem) && (f3 == 3'b001);
  assign sfence  = (inst.std.funct7 == 7'b0001001) && (f3 == 3'b000)
                && (inst.std.rd == '0) && (opc == 7'b1110011);

  assign decd.load  = c_load || std_load || ro_load || is_lr || amo_wd && amo_as_ld;
  assign decd.store = c_store || std_store || ro_store || fence_i || sfence || is_sc
                   || amo_wd && !amo_as_ld;
  assign decd.str   = ro_store;
  assign decd.sync  = fence || fence_i || sfence || is_lr || is_sc || amo_wd;
  assign decd.bar   = fence;

  // ==============================
  // barrier type
  // ==============================
  // anything other than plain r/w ordering is treated as a full barrier
  // so the lsiq cannot deadlock on a partial one
  assign pred    = {inst.std.funct7[2:0], inst.std.rs2[4]};  // i, o, r, w
  assign succ    = inst.std.rs2[3:0];
  assign rw_only = (pred[1] || pred[0]) && !(pred[3] || pred[2])
                && (succ[1] || succ[0]) && !(succ[3] || succ[2]);
  assign decd.bar_type = rw_only ? bar_type_rw : bar_type_all;

endmodule

// File: verilog/ir_decd_bju.sv
// branch field decoder
// return, call and pc fifo flags

`include "ir_decd_params.svh"

module ir_decd_bju
  import rv_inst_pkg::*;
(
  input rv_inst_u inst,
  ir_decd_if.bju  decd
);

  logic [5:0] c_key;   // c_funct3, c_bit12, c_op
  logic       c_jr;
  logic       c_jalr;
  logic       jal;
  logic       jalr;
  logic       branch;

  // x1 and x5 are the link registers
  function automatic logic is_link(input logic [`IR_REG_W-1:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  assign c_key  = {inst.cmp.c_funct3, inst.cmp.c_bit12, inst.cmp.c_op};
  assign c_jr   = (c_key == 6'b100_0_10) && (inst.cmp.c_rs2 == '0);
  assign c_jalr = (c_key == 6'b100_1_10) && (inst.cmp.c_rs2 == '0);
  assign jal    = inst.std.opcode == op_jal;
  assign jalr   = (inst.std.opcode == op_jalr) && (inst.std.funct3 == 3'b000);
  assign branch = (inst.std.opcode == op_branch)
               && !(inst.std.funct3 inside {3'b010, 3'b011});  // no such branches

  // ==============================
  // return stack
  // ==============================
  assign decd.rts   = c_jr && is_link(inst.cmp.c_rd)
                   || c_jalr && (inst.cmp.c_rd == 5'd5)
                   || jalr && is_link(inst.std.rs1) && (inst.std.rs1 != inst.std.rd);
  assign decd.pcall = c_jalr && (inst.cmp.c_rd != '0)
                   || (jal || jalr) && is_link(inst.std.rd);

  // ==============================
  // pc fifo
  // ==============================
  assign decd.pcfifo = ({inst.cmp.c_funct3, inst.cmp.c_op} inside {5'b101_01, 5'b110_01,
                                                                  5'b111_01})
                    || (c_jr || c_jalr) && (inst.cmp.c_rd != '0)
                    || jal || jalr || branch
                    || (inst.std.opcode == op_auipc)
                    || (inst.std.opcode == 7'b0011111);     // pseudo auipc

endmodule

// File: verilog/ir_decd_vfpu.sv
// vector and floating point field decoder
// vec/fp class, divide, moves, multiply, short latency, vset*, vamo

module ir_decd_vfpu
  import rv_inst_pkg::*;
  import ir_decd_pkg::*;
(
  input rv_inst_u inst,
  ir_decd_if.vfpu decd
);

  logic [6:0] f7;
  logic [5:0] f6;        // bits 31:26
  logic [3:0] f4;        // bits 31:28
  logic [2:0] f3;
  logic       vec;
  logic       fp_op;
  logic       fmt_ok;    // s, d or h format
  logic       is_ivv, is_ivx, is_ivi;
  logic       is_mvv, is_mvx;
  logic       is_fvv, is_fvf;
  logic       is_iv;
  logic       is_mv;
  logic       vmul_norm, vmac_norm, vmul_wide, vmac_wide;
  logic       redu, narr_vsft, vcmp, permu;

  assign f7     = inst.std.funct7;
  assign f6     = f7[6:1];
  assign f4     = f7[6:3];
  assign f3     = inst.std.funct3;
  assign vec    = inst.std.opcode == op_v;
  assign fp_op  = inst.std.opcode == op_fp;
  assign fmt_ok = f7[1:0] != 2'b11;

  assign is_ivv = f3 == opivv;
  assign is_ivx = f3 == opivx;
  assign is_ivi = f3 == opivi;
  assign is_mvv = f3 == opmvv;
  assign is_mvx = f3 == opmvx;
  assign is_fvv = f3 == opfvv;
  assign is_fvf = f3 == opfvf;
  assign is_iv  = is_ivv || is_ivx || is_ivi;
  assign is_mv  = is_mvv || is_mvx;

  // ==============================
  // class and divide
  // ==============================
  assign decd.vec  = vec;
  assign decd.fp   = fp_op
                  || (inst.std.opcode[6:4] == 3'b100) && (inst.cmp.c_op == 2'b11); // fmadd..
  assign decd.vdiv = vec && ((f4 == 4'b1000) && is_mv                  // vdiv, vrem
                          || (f6 == 6'b100000) && (is_fvv || is_fvf)   // vfdiv
                          || (f6 == 6'b100001) && is_fvf               // vfrdiv
                          || (f6 == 6'b100011) && is_fvv && (inst.std.rs1 == '0));

  // ==============================
  // fp and vector moves
  // ==============================
  assign decd.mfvr = fp_op && (f7[6:2] == 5'b11100) && fmt_ok && (inst.std.rs2 == '0)
                     && (f3[2:1] == 2'b00)                      // fmv.x.*, fclass.*
                  || fp_op && (f7[6:2] == 5'b10100) && fmt_ok && (f3 != 3'b011)
                     && !f3[2]                                  // feq, flt, fle
                  || vec && (f7 == 7'b0011001) && is_mvv        // vext
                  || vec && (f7 == 7'b0010001) && (inst.std.rs1 == '0) && is_fvv;
  assign decd.mtvr = fp_op && (f7[6:2] == 5'b11110) && fmt_ok && (inst.std.rs2 == '0)
                     && (f3 == 3'b000)                          // fmv.*.x
                  || vec && (inst.std.rs2 == '0)
                     && ((f7 == 7'b0011011) && is_mvx           // vmv.s.x
                      || (f7 == 7'b0101111) && is_ivx           // vmv.v.x
                      || (f7 == 7'b0011001) && is_fvf);         // vfmv.s.f

  // ==============================
  // multiply and short latency
  // ==============================
  assign vmul_norm = (f6 == 6'b100111) && (is_ivv || is_ivx) || (f4 == 4'b1001) && is_mv;
  assign vmac_norm = (f6[5:3] == 3'b101) && f6[0] && is_mv;     // vmadd, vnmsub, vmacc..
  assign vmul_wide = ((f6 == 6'b111000) || (f6[5:1] == 5'b11101)) && is_mv;
  assign vmac_wide = (f4 == 4'b1111) && (is_ivv || is_ivx || is_mv);
  assign decd.vmul = vec && (vmul_norm || vmac_norm || vmul_wide || vmac_wide);

  assign redu      = (f6[5:1] == 5'b10011) && is_ivv || (f6[5:3] == 3'b000) && is_mvv;
  assign narr_vsft = (f4 == 4'b1011) && is_iv;                  // vnsrl, vnclip..
  assign vcmp      = (f6[5:3] == 3'b011) && is_iv;
  assign permu     = (f6 == 6'b001100) && is_iv                 // vrgather
                  || (f6[5:1] == 5'b00111) && (is_ivx || is_ivi || is_mvx)
                  || (f6 == 6'b010111) && is_mvv;               // vcompress
  assign decd.vmla_short = vec && (redu || narr_vsft || vcmp || permu);

  // ==============================
  // vset and memory hints
  // ==============================
  assign decd.vsetvli     = vec && (f3 == 3'b111) && !f7[6];
  assign decd.vsetvl      = vec && (f3 == 3'b111) && (f7 == 7'b1000000);
  assign decd.unit_stride = (f7[2:1] == 2'b00) && (f7[6:4] == 3'b000);
  assign decd.vamo        = (inst.std.opcode == op_amo) || (|f7[6:4]);

endmodule

// File: verilog/ir_decd_pipe.sv
// decode stage register
// masks flags of invalid or illegal instructions, then holds them one cycle

`include "ir_decd_params.svh"

module ir_decd_pipe (
  input  logic                 forever_cpuclk,
  input  logic                 rst,
  input  logic                 inst_vld,
  input  logic                 illegal,     // id stage keeps the opcode
  ir_decd_if.pipe              decd,
  output logic                 load, store, str, sync, bar,
  output logic                 rts, pcall, pcfifo,
  output logic                 vec, fp, vdiv, mfvr, mtvr, vmul, vmla_short,
  output logic                 vsetvl, vsetvli, unit_stride, vamo,
  output logic [`IR_BAR_W-1:0] bar_type,
  output logic                 out_vld
);

  localparam int flag_n = 19;

  logic              keep;
  logic [flag_n-1:0] flag_in;
  logic [flag_n-1:0] flag_q;

  assign keep = inst_vld && !illegal;

  // ==============================
  // gate and register
  // ==============================
  assign flag_in = {decd.load, decd.store, decd.str, decd.sync, decd.bar,
                    decd.rts, decd.pcall, decd.pcfifo,
                    decd.vec, decd.fp, decd.vdiv, decd.mfvr, decd.mtvr,
                    decd.vmul, decd.vmla_short, decd.vsetvl, decd.vsetvli,
                    decd.unit_stride, decd.vamo} & {flag_n{keep}};

  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      flag_q   <= '0;
      bar_type <= '0;
      out_vld  <= 1'b0;
    end else begin
      flag_q   <= flag_in;
      bar_type <= decd.bar_type & {`IR_BAR_W{keep}};
      out_vld  <= inst_vld;              // valid passes even when illegal
    end
  end

  assign {load, store, str, sync, bar,
          rts, pcall, pcfifo,
          vec, fp, vdiv, mfvr, mtvr,
          vmul, vmla_short, vsetvl, vsetvli,
          unit_stride, vamo} = flag_q;

endmodule

// File: verilog/ct_ir_decd.sv
// instruction register decode stage top level
// three field decoders feeding one stage register

`include "ir_decd_params.svh"

module ct_ir_decd (
  input  logic                  forever_cpuclk,
  input  logic                  rst,
  input  logic                  inst_vld,
  input  logic [`IR_INST_W-1:0] inst,
  input  logic                  illegal,
  input  logic                  type_staddr,
  input  logic                  type_vload,
  output logic                  out_vld,
  output logic                  load, store, str, sync, bar,
  output logic [`IR_BAR_W-1:0]  bar_type,
  output logic                  rts, pcall, pcfifo,
  output logic                  vec, fp, vdiv, mfvr, mtvr, vmul, vmla_short,
  output logic                  vsetvl, vsetvli, unit_stride, vamo
);

  ir_decd_if decd ();

  // ==============================
  // field decoders
  // ==============================
  ir_decd_lsu u_lsu (
    .inst        (inst),
    .type_staddr (type_staddr),
    .type_vload  (type_vload),
    .decd        (decd.lsu)
  );

  ir_decd_bju u_bju (
    .inst (inst),
    .decd (decd.bju)
  );

  ir_decd_vfpu u_vfpu (
    .inst (inst),
    .decd (decd.vfpu)
  );

  // ==============================
  // stage register
  // ==============================
  ir_decd_pipe u_pipe (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .inst_vld       (inst_vld),
    .illegal        (illegal),
    .decd           (decd.pipe),
    .load           (load),
    .store          (store),
    .str            (str),
    .sync           (sync),
    .bar            (bar),
    .rts            (rts),
    .pcall          (pcall),
    .pcfifo         (pcfifo),
    .vec            (vec),
    .fp             (fp),
    .vdiv           (vdiv),
    .mfvr           (mfvr),
    .mtvr           (mtvr),
    .vmul           (vmul),
    .vmla_short     (vmla_short),
    .vsetvl         (vsetvl),
    .vsetvli        (vsetvli),
    .unit_stride    (unit_stride),
    .vamo           (vamo),
    .bar_type       (bar_type),
    .out_vld        (out_vld)
  );

endmodule

// File: verif/tb_ct_ir_decd.sv
// directed testbench for the instruction register decode stage
// clock, reset, per-behavior test tasks, flag checks and a cycle timeout

`include "ir_decd_params.svh"

module tb_ct_ir_decd;
  timeunit 1ns;
  timeprecision 1ps;

  // about 100 cycles of tests, limit set with margin
  localparam int max_cycles = 400;

  // bit positions in the observed flag vector
  localparam logic [18:0] f_load    = 19'd1 << 0,
                          f_store   = 19'd1 << 1,
                          f_str     = 19'd1 << 2,
                          f_sync    = 19'd1 << 3,
                          f_bar     = 19'd1 << 4,
                          f_rts     = 19'd1 << 5,
                          f_pcall   = 19'd1 << 6,
                          f_pcfifo  = 19'd1 << 7,
                          f_vec     = 19'd1 << 8,
                          f_fp      = 19'd1 << 9,
                          f_vdiv    = 19'd1 << 10,
                          f_mfvr    = 19'd1 << 11,
                          f_mtvr    = 19'd1 << 12,
                          f_vmul    = 19'd1 << 13,
                          f_vmla    = 19'd1 << 14,
                          f_vsetvl  = 19'd1 << 15,
                          f_vsetvli = 19'd1 << 16,
                          f_ustride = 19'd1 << 17,
                          f_vamo    = 19'd1 << 18;

  // unit_stride and vamo follow raw funct7 bits on every opcode
  localparam logic [18:0] dir_care = ~(f_ustride | f_vamo);

  string flag_name [19] = '{"load", "store", "str", "sync", "bar", "rts", "pcall", "pcfifo",
                            "vec", "fp", "vdiv", "mfvr", "mtvr", "vmul", "vmla_short",
                            "vsetvl", "vsetvli", "unit_stride", "vamo"};

  logic                  clk;
  logic                  rst;
  logic                  inst_vld;
  logic [`IR_INST_W-1:0] inst;
  logic                  illegal;
  logic                  type_staddr;
  logic                  type_vload;
  logic                  out_vld;
  logic                  load, store, str, sync, bar;
  logic [`IR_BAR_W-1:0]  bar_type;
  logic                  rts, pcall, pcfifo;
  logic                  vec, fp, vdiv, mfvr, mtvr, vmul, vmla_short;
  logic                  vsetvl, vsetvli, unit_stride, vamo;
  logic [18:0]           obs;
  int                    errors = 0;
  int                    checks = 0;
  int                    cycles = 0;

  assign obs = {vamo, unit_stride, vsetvli, vsetvl, vmla_short, vmul, mtvr, mfvr, vdiv, fp,
                vec, pcfifo, pcall, rts, bar, sync, str, store, load};

  ct_ir_decd dut_i (.forever_cpuclk(clk), .*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run still going after %0d cycles", max_cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // ==============================
  // encoders and drive/check
  // ==============================
  function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_c(input logic [2:0] f3, input logic b12,
                                        input logic [4:0] rd, rs2, input logic [1:0] op);
    return {16'h0000, f3, b12, rd, rs2, op};  // 16-bit form in low half
  endfunction

  task automatic apply(input logic [31:0] word, input logic vld, ill, ts, tv);
    @(posedge clk);
    inst        <= word;
    inst_vld    <= vld;
    illegal     <= ill;
    type_staddr <= ts;
    type_vload  <= tv;
  endtask

  task automatic check_out(input string tag, input logic exp_vld, input logic [18:0] exp_f,
                           input logic [18:0] care, input logic chk_bar,
                           input logic [3:0] exp_bar);
    int i;
    checks++;
    for (i = 0; i < 19; i++) begin
      if (care[i] && (obs[i] !== exp_f[i])) begin
        errors++;
        $display("MISMATCH t=%0t %s: %s got %b exp %b", $time, tag, flag_name[i],
                 obs[i], exp_f[i]);
      end
    end
    if (out_vld !== exp_vld) begin
      errors++;
      $display("MISMATCH t=%0t %s: out_vld got %b exp %b", $time, tag, out_vld, exp_vld);
    end
    if (chk_bar && (bar_type !== exp_bar)) begin
      errors++;
      $display("MISMATCH t=%0t %s: bar_type got %b exp %b", $time, tag, bar_type, exp_bar);
    end
  endtask

  // one instruction, then idle, result checked one cycle after capture
  task automatic send_check(input string tag, input logic [31:0] word,
                            input logic vld, ill, ts, tv, input logic [18:0] exp_f,
                            input logic [18:0] care, input logic chk_bar,
                            input logic [3:0] exp_bar);
    apply(word, vld, ill, ts, tv);
    apply('0, 1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    check_out(tag, vld, exp_f, care, chk_bar, exp_bar);
  endtask

  task automatic dec(input string tag, input logic [31:0] word, input logic [18:0] exp_f);
    send_check(tag, word, 1'b1, 1'b0, 1'b0, 1'b0, exp_f, dir_care, 1'b0, '0);
  endtask

  // ==============================
  // tests
  // ==============================
  task automatic test_reset();
    @(posedge clk);
    @(negedge clk);
    check_out("in reset", 1'b0, '0, '1, 1'b1, '0);
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_out("reset release", 1'b0, '0, '1, 1'b1, '0);
  endtask

  task automatic test_load_store();
    logic [31:0] amo_w;
    logic [31:0] amo_v;
    amo_w = enc(7'h00, 5'd11, 5'd10, 3'b010, 5'd5, 7'b0101111);  // amoadd.w
    amo_v = enc(7'h00, 5'd11, 5'd10, 3'b110, 5'd5, 7'b0101111);  // bit 14 set
    dec("lw", enc(7'h00, 5'd0, 5'd10, 3'b010, 5'd5, 7'b0000011), f_load);
    dec("c.lwsp x0", enc_c(3'b010, 1'b0, 5'd0, 5'd4, 2'b10), '0);
    dec("c.lwsp x5", enc_c(3'b010, 1'b0, 5'd5, 5'd4, 2'b10), f_load);
    dec("lr.w rs2 x3", enc(7'b0001000, 5'd3, 5'd10, 3'b010, 5'd5, 7'b0101111), '0);
    dec("lr.w", enc(7'b0001000, 5'd0, 5'd10, 3'b010, 5'd5, 7'b0101111), f_load | f_sync);
    dec("flrw", enc(7'b0100000, 5'd11, 5'd10, 3'b110, 5'd1, 7'b0001011), f_load);
    dec("srw", enc(7'b0001000, 5'd11, 5'd10, 3'b101, 5'd6, 7'b0001011), f_store | f_str);
    dec("sc.d", enc(7'b0001100, 5'd11, 5'd10, 3'b011, 5'd5, 7'b0101111), f_store | f_sync);
    dec("fence.i", enc(7'h00, 5'd0, 5'd0, 3'b001, 5'd0, 7'b0001111), f_store | f_sync);
    send_check("amo staddr 0", amo_w, 1'b1, 1'b0, 1'b0, 1'b0, f_load | f_sync, dir_care,
               1'b0, '0);
    send_check("amo staddr 1", amo_w, 1'b1, 1'b0, 1'b1, 1'b0, f_store | f_sync, dir_care,
               1'b0, '0);
    send_check("amo vload 1", amo_v, 1'b1, 1'b0, 1'b1, 1'b1, f_load | f_sync, dir_care,
               1'b0, '0);
    send_check("amo vload 0", amo_v, 1'b1, 1'b0, 1'b0, 1'b0, f_store | f_sync, dir_care,
               1'b0, '0);
  endtask

  task automatic test_branch();
    dec("jal x1", enc(7'h00, 5'd0, 5'd0, 3'b000, 5'd1, 7'b1101111), f_pcall | f_pcfifo);
    dec("jalr x0,x1", enc(7'h00, 5'd0, 5'd1, 3'b000, 5'd0, 7'b1100111), f_rts | f_pcfifo);
    dec("c.jr x1", enc_c(3'b100, 1'b0, 5'd1, 5'd0, 2'b10), f_rts | f_pcfifo);
    dec("beq", enc(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, 7'b1100011), f_pcfifo);
    dec("auipc", enc(7'h00, 5'd0, 5'd0, 3'b000, 5'd3, 7'b0010111), f_pcfifo);
    dec("jal x0", enc(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, 7'b1101111), f_pcfifo);
  endtask

  task automatic test_barrier();
    // pred 0011 and succ 0011 is fence rw,rw
    send_check("fence rw", 32'h0330000f, 1'b1, 1'b0, 1'b0, 1'b0, f_sync | f_bar, dir_care,
               1'b1, 4'b1010);
    send_check("fence full", 32'h0ff0000f, 1'b1, 1'b0, 1'b0, 1'b0, f_sync | f_bar, dir_care,
               1'b1, 4'b1111);
    send_check("add", 32'h00000033, 1'b1, 1'b0, 1'b0, 1'b0, '0, dir_care, 1'b1, 4'b1111);
  endtask

  task automatic test_vfpu();
    dec("vdivu.vv", enc(7'b1000001, 5'd2, 5'd3, 3'b010, 5'd1, 7'b1010111), f_vec | f_vdiv);
    dec("vfsqrt.v", enc(7'b1000111, 5'd2, 5'd0, 3'b001, 5'd1, 7'b1010111), f_vec | f_vdiv);
    dec("fmv.x.w", enc(7'b1110000, 5'd0, 5'd1, 3'b000, 5'd5, 7'b1010011), f_fp | f_mfvr);
    dec("vmv.s.x", enc(7'b0011011, 5'd0, 5'd5, 3'b110, 5'd1, 7'b1010111), f_vec | f_mtvr);
    dec("vmul.vx", enc(7'b1001011, 5'd2, 5'd5, 3'b110, 5'd1, 7'b1010111), f_vec | f_vmul);
    dec("vredsum", enc(7'b0000001, 5'd2, 5'd3, 3'b010, 5'd1, 7'b1010111), f_vec | f_vmla);
    dec("vsetvli", enc(7'h00, 5'd8, 5'd10, 3'b111, 5'd5, 7'b1010111), f_vec | f_vsetvli);
    dec("vsetvl", enc(7'b1000000, 5'd11, 5'd10, 3'b111, 5'd5, 7'b1010111), f_vec | f_vsetvl);
    dec("fadd.s", enc(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, 7'b1010011), f_fp);
  endtask

  task automatic test_stream();
    logic [31:0] lw;
    logic [31:0] tab_w [4];
    logic [18:0] tab_e [4];
    logic [31:0] s_w [20];
    logic [18:0] s_e [20];
    logic [31:0] r;
    int          i;
    lw = enc(7'h00, 5'd0, 5'd10, 3'b010, 5'd5, 7'b0000011);
    send_check("lw illegal", lw, 1'b1, 1'b1, 1'b0, 1'b0, '0, '1, 1'b1, '0);
    send_check("lw invalid", lw, 1'b0, 1'b0, 1'b0, 1'b0, '0, '1, 1'b1, '0);
    tab_w[0] = lw;
    tab_e[0] = f_load;
    tab_w[1] = enc(7'h00, 5'd0, 5'd0, 3'b000, 5'd1, 7'b1101111);        // jal x1
    tab_e[1] = f_pcall | f_pcfifo;
    tab_w[2] = enc(7'b0001100, 5'd11, 5'd10, 3'b011, 5'd5, 7'b0101111); // sc.d
    tab_e[2] = f_store | f_sync;
    tab_w[3] = enc(7'b1001011, 5'd2, 5'd5, 3'b110, 5'd1, 7'b1010111);   // vmul.vx
    tab_e[3] = f_vec | f_vmul;
    for (i = 0; i < 20; i++) begin
      if (i % 3 == 2) begin
        r = $urandom();
        s_w[i] = {r[31:7], 7'b0110011};  // int reg-reg, no checked flag set
        s_e[i] = '0;
      end else begin
        s_w[i] = tab_w[i % 4];
        s_e[i] = tab_e[i % 4];
      end
    end
    for (i = 0; i < 20; i++) begin
      apply(s_w[i], 1'b1, 1'b0, 1'b0, 1'b0);
      @(negedge clk);
      if (i > 0) begin
        check_out($sformatf("stream %0d", i - 1), 1'b1, s_e[i-1], dir_care, 1'b0, '0);
      end
    end
    apply('0, 1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    check_out("stream 19", 1'b1, s_e[19], dir_care, 1'b0, '0);
  endtask

  initial begin
    void'($urandom(32'h9f31));
    rst         = 1'b1;
    inst_vld    = 1'b0;
    inst        = '0;
    illegal     = 1'b0;
    type_staddr = 1'b0;
    type_vload  = 1'b0;
    test_reset();
    test_load_store();
    test_branch();
    test_barrier();
    test_vfpu();
    test_stream();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: ct_ir_decd.f
+incdir+verilog
verilog/rv_inst_pkg.sv
verilog/ir_decd_pkg.sv
verilog/ir_decd_if.sv
verilog/ir_decd_lsu.sv
verilog/ir_decd_bju.sv
verilog/ir_decd_vfpu.sv
verilog/ir_decd_pipe.sv
verilog/ct_ir_decd.sv
verif/tb_ct_ir_decd.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_ct_ir_decd -f ct_ir_decd.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0
